// ==== tests/aes_dec_input.txt ====
# k <round key address> <round key>   v <ciphertext> <expected plaintext>
# r <ciphertext> starts a block that is cut off by a reset
# Key set 1, FIPS-197 C.3 schedule
k 0 000102030405060708090a0b0c0d0e0f
k 1 101112131415161718191a1b1c1d1e1f
k 2 a573c29fa176c498a97fce93a572c09c
k 3 1651a8cd0244beda1a5da4c10640bade
k 4 ae87dff00ff11b68a68ed5fb03fc1567
k 5 6de1f1486fa54f9275f8eb5373b8518d
k 6 c656827fc9a799176f294cec6cd5598b
k 7 3de23a75524775e727bf9eb45407cf39
k 8 0bdc905fc27b0948ad5245a4c1871c2f
k 9 45f5a66017b2d387300d4d33640a820a
k a 7ccff71cbeb4fe5413e6bbf0d261a7df
k b f01afafee7a82979d7a5644ab3afe640
k c 2541fe719bf500258813bbd55a721c0a
k d 4e5a6699a9f24fe07e572baacdf8cdea
k e 24fc79ccbf0979e9371ac23c6d68de36
v 8ea2b7ca516745bfeafc49904b496089 00112233445566778899aabbccddeeff
v 8ea2b7ca516745bfeafc49904b496089 00112233445566778899aabbccddeeff
v 8ea2b7ca516745bfeafc49904b496089 00112233445566778899aabbccddeeff
# Key set 2, FIPS-197 A.3 schedule
k 0 603deb1015ca71be2b73aef0857d7781
k 1 1f352c073b6108d72d9810a30914dff4
k 2 9ba354118e6925afa51a8b5f2067fcde
k 3 a8b09c1a93d194cdbe49846eb75d5b9a
k 4 d59aecb85bf3c917fee94248de8ebe96
k 5 b5a9328a2678a647983122292f6c79b3
k 6 812c81addadf48ba24360af2fab8b464
k 7 98c5bfc9bebd198e268c3ba709e04214
k 8 68007bacb2df331696e939e46c518d80
k 9 c814e20476a9fb8a5025c02d59c58239
k a de1369676ccc5a71fa2563959674ee15
k b 5886ca5d2e2f31d77e0af1fa27cf73c3
k c 749c47ab18501ddae2757e4f7401905a
k d cafaaae3e4d59b349adf6acebd10190d
k e fe4890d1e6188d0b046df344706c631e
v f3eed1bdb5d2a03c064b5a7e3db181f8 6bc1bee22e409f96e93d7e117393172a
v 591ccb10d410ed26dc5ba74a31362870 ae2d8a571e03ac9c9eb76fac45af8e51
v b6ed21b99ca6f4f9f153e7b1beafed1d 30c81c46a35ce411e5fbc1191a0a52ef
v 23304b7a39f9f3ff067d8d8f9e24ecc7 f69f2445df4f9b17ad2b417be66c3710
# Reset in the middle of a block, then a clean block
r f3eed1bdb5d2a03c064b5a7e3db181f8
v 591ccb10d410ed26dc5ba74a31362870 ae2d8a571e03ac9c9eb76fac45af8e51

// ==== aes_dec_top.f ====
+incdir+hdl
hdl/aes_dec_pkg.sv
hdl/aes_inv_sbox.sv
hdl/aes_inv_sub_bytes.sv
hdl/aes_inv_mix_columns.sv
hdl/aes_round_key_ram.sv
hdl/aes_dec_core.sv
hdl/aes_dec_top.sv
tests/aes_dec_tb.sv

// ==== Bender.yml ====
package:
  name: aes_dec

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/aes_dec_pkg.sv
      - hdl/aes_inv_sbox.sv
      - hdl/aes_inv_sub_bytes.sv
      - hdl/aes_inv_mix_columns.sv
      - hdl/aes_round_key_ram.sv
      - hdl/aes_dec_core.sv
      - hdl/aes_dec_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/aes_dec_tb.sv

// ==== tests/aes_dec_tb.sv ====
`timescale 1ns/1ps

`include "aes_dec_params.svh"

module aes_dec_tb;

    import aes_dec_pkg::*;

    localparam int CLK_HALF = 2;
    localparam int MAX_GAP  = 12;

    logic                       clk;
    logic                       resetn;
    logic                       key_wr_en;
    logic [`AES_DEC_KEY_AW-1:0] key_wr_addr;
    aes_state_t                 key_wr_data;
    logic                       data_in_valid;
    aes_state_t                 data_in;
    logic                       data_out_valid;
    aes_state_t                 data_out;
    logic                       busy;

    // Parsed records with kind, key address and two 128-bit fields
    byte        rec_kind[$];
    int         rec_addr[$];
    aes_state_t rec_a[$];
    aes_state_t rec_b[$];

    int          pass_count;
    int          fail_count;
    int          errors;
    int          blocks;
    int          block_limit;
    int          watchdog_cycles;
    logic        loaded;
    dec_state_e  state_probe;

    aes_dec_top i_dut
    (
        .clk            (clk),
        .resetn         (resetn),
        .key_wr_en      (key_wr_en),
        .key_wr_addr    (key_wr_addr),
        .key_wr_data    (key_wr_data),
        .data_in_valid  (data_in_valid),
        .data_in        (data_in),
        .data_out_valid (data_out_valid),
        .data_out       (data_out),
        .busy           (busy)
    );

    initial
    begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    task automatic check_value(input string name, input aes_state_t expected,
                               input aes_state_t actual);
        assert (actual == expected)
        else
        begin
            $display("mismatch %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        if (errors == err_before)
        begin
            pass_count++;
            $display("test %s: pass", name);
        end
        else
        begin
            fail_count++;
            $display("test %s: FAIL", name);
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        resetn = 1'b0;
        repeat (10) @(negedge clk);
        resetn = 1'b1;
    endtask

    task automatic check_idle_outputs();
        check_value("busy", '0, busy);
        check_value("data_out_valid", '0, data_out_valid);
        check_value("data_out", '0, data_out);
    endtask

    task automatic write_key(input int addr, input aes_state_t key);
        key_wr_en   = 1'b1;
        key_wr_addr = addr[`AES_DEC_KEY_AW-1:0];
        key_wr_data = key;
        @(negedge clk);
        key_wr_en = 1'b0;
    endtask

    // One block with a random lead gap and a stray strobe while busy
    task automatic run_block(input aes_state_t cipher, input aes_state_t plain, input int idx);
        int   err_before;
        int   gap;
        int   stray_at;
        int   cycles;
        logic seen;
        err_before = errors;
        gap        = $urandom % MAX_GAP;
        stray_at   = 1 + ($urandom % 100);
        repeat (gap) @(negedge clk);
        data_in       = cipher;
        data_in_valid = 1'b1;
        @(negedge clk);
        data_in_valid = 1'b0;
        cycles = 1;
        seen   = 1'b0;
        while (!seen && cycles <= block_limit)
        begin
            if (data_out_valid)
            begin
                seen = 1'b1;
                check_value("busy", '0, busy);
                check_value("data_out", plain, data_out);
            end
            else
            begin
                assert (busy)
                else
                begin
                    $display("busy dropped before the result of vector %0d", idx);
                    errors++;
                end
                if (cycles == stray_at)
                begin
                    data_in       = ~cipher;
                    data_in_valid = 1'b1;
                end
                @(negedge clk);
                data_in_valid = 1'b0;
                cycles++;
            end
        end
        assert (seen)
        else
        begin
            $display("no data_out_valid for vector %0d within %0d cycles", idx, block_limit);
            errors++;
        end
        if (seen)
        begin
            // A second accepted block would keep the core busy here
            @(negedge clk);
            check_value("data_out_valid", '0, data_out_valid);
            check_value("busy", '0, busy);
        end
        finish_test($sformatf("vector %0d", idx), err_before);
    endtask

    task automatic run_reset(input aes_state_t cipher);
        int err_before;
        int hold;
        err_before    = errors;
        hold          = 5 + ($urandom % 200);
        data_in       = cipher;
        data_in_valid = 1'b1;
        @(negedge clk);
        data_in_valid = 1'b0;
        repeat (hold)
        begin
            check_value("data_out_valid", '0, data_out_valid);
            @(negedge clk);
        end
        assert (busy)
        else
        begin
            $display("block finished before the reset was applied");
            errors++;
        end
        resetn = 1'b0;
        @(negedge clk);
        check_idle_outputs();
        repeat (9) @(negedge clk);
        resetn = 1'b1;
        @(negedge clk);
        check_idle_outputs();
        finish_test("reset during block", err_before);
    endtask

    task automatic load_records(output logic ok);
        int               fd;
        int               code;
        int               addr;
        logic [63:0]      tag;
        logic [8*256-1:0] line;
        aes_state_t       a;
        aes_state_t       b;
        ok = 1'b1;
        fd = $fopen("tests/aes_dec_input.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open tests/aes_dec_input.txt");
            ok = 1'b0;
        end
        else
        begin
            code = $fscanf(fd, "%s", tag);
            while (code == 1 && ok)
            begin
                addr = 0;
                b    = '0;
                if (tag == "#")
                    code = $fgets(line, fd);
                else if (tag == "k" || tag == "v" || tag == "r")
                begin
                    if (tag == "k")
                        code = $fscanf(fd, "%h %h", addr, a) - 2;
                    else if (tag == "v")
                        code = $fscanf(fd, "%h %h", a, b) - 2;
                    else
                        code = $fscanf(fd, "%h", a) - 1;
                    if (code != 0)
                    begin
                        $display("malformed record in the data file");
                        ok = 1'b0;
                    end
                    if (tag != "k")
                        blocks++;
                    rec_kind.push_back(tag[7:0]);
                    rec_addr.push_back(addr);
                    rec_a.push_back(a);
                    rec_b.push_back(b);
                end
                else
                begin
                    $display("unknown record tag in the data file");
                    ok = 1'b0;
                end
                code = $fscanf(fd, "%s", tag);
            end
            $fclose(fd);
        end
    endtask

    task automatic run_records();
        int vec;
        vec = 0;
        for (int i = 0; i < rec_kind.size(); i++)
        begin
            case (rec_kind[i])
                "k": write_key(rec_addr[i], rec_a[i]);
                "v":
                begin
                    vec++;
                    run_block(rec_a[i], rec_b[i], vec);
                end
                "r": run_reset(rec_a[i]);
                default:
                begin
                end
            endcase
        end
    endtask

    // Watchdog armed once the block count is known
    initial
    begin
        wait (loaded);
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles", watchdog_cycles);
        $display("Some tests failed");
        $finish;
    end

    initial
    begin
        logic ok;
        int   err_before;
        resetn        = 1'b0;
        key_wr_en     = 1'b0;
        key_wr_addr   = '0;
        key_wr_data   = '0;
        data_in_valid = 1'b0;
        data_in       = '0;
        pass_count    = 0;
        fail_count    = 0;
        errors        = 0;
        blocks        = 0;
        loaded        = 1'b0;
        void'($urandom(32'hf449));
        // Sub-bytes feed plus one cycle per FSM state in every round
        block_limit = `AES_DEC_ROUNDS * (16 + state_probe.num()) + 20;
        load_records(ok);
        if (!ok)
        begin
            fail_count++;
        end
        else
        begin
            watchdog_cycles = blocks * (block_limit + MAX_GAP + 20) + 500;
            loaded          = 1'b1;
            apply_reset();
            err_before = errors;
            check_idle_outputs();
            finish_test("reset values", err_before);
            run_records();
        end
        $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// ==== hdl/aes_dec_top.sv ====
`timescale 1ns/1ps

`include "aes_dec_params.svh"

module aes_dec_top
(
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       key_wr_en,
    input  logic [`AES_DEC_KEY_AW-1:0] key_wr_addr,
    input  aes_dec_pkg::aes_state_t     key_wr_data,
    input  logic                       data_in_valid,
    input  aes_dec_pkg::aes_state_t     data_in,
    output logic                       data_out_valid,
    output aes_dec_pkg::aes_state_t     data_out,
    output logic                       busy
);

    import aes_dec_pkg::*;

    logic [`AES_DEC_KEY_AW-1:0] key_rd_addr;
    aes_state_t                 key_rd_data;

    aes_round_key_ram i_key_ram
    (
        .clk         (clk),
        .resetn      (resetn),
        .key_wr_en   (key_wr_en),
        .key_wr_addr (key_wr_addr),
        .key_wr_data (key_wr_data),
        .key_rd_addr (key_rd_addr),
        .key_rd_data (key_rd_data)
    );

    aes_dec_core i_core
    (
        .clk            (clk),
        .resetn         (resetn),
        .data_in_valid  (data_in_valid),
        .data_in        (data_in),
        .key_rd_data    (key_rd_data),
        .key_rd_addr    (key_rd_addr),
        .data_out_valid (data_out_valid),
        .busy           (busy),
        .data_out       (data_out)
    );

endmodule

// ==== hdl/aes_dec_core.sv ====
`timescale 1ns/1ps

`include "aes_dec_params.svh"

module aes_dec_core
(
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       data_in_valid,
    input  aes_dec_pkg::aes_state_t     data_in,
    input  aes_dec_pkg::aes_state_t     key_rd_data,
    output logic [`AES_DEC_KEY_AW-1:0] key_rd_addr,
    output logic                       data_out_valid,
    output logic                       busy,
    output aes_dec_pkg::aes_state_t     data_out
);

    import aes_dec_pkg::*;

    // Last round number and address of the first key used
    localparam logic [`AES_DEC_KEY_AW-1:0] NR = `AES_DEC_ROUNDS;

    dec_state_e state;
    dec_state_e state_next;
    logic [`AES_DEC_KEY_AW-1:0] round;

    aes_state_t in_q;
    aes_state_t state_q;
    aes_state_t next_block;
    aes_state_t sb_out;
    aes_state_t mc_out;
    logic       sb_start;
    logic       sb_done;
    logic       mc_en;

    assign busy     = (state != ST_IDLE);
    assign sb_start = (state == ST_SB_START);
    assign mc_en    = (state == ST_MIX);

    always_comb
    begin
        state_next = state;
        case (state)
            ST_IDLE:
            begin
                if (data_in_valid)
                    state_next = ST_FIRST_ADD;
            end
            ST_FIRST_ADD: state_next = ST_SB_START;
            ST_SB_START:  state_next = ST_SB_WAIT;
            ST_SB_WAIT:
            begin
                if (sb_done)
                    state_next = ST_ADD_KEY;
            end
            ST_ADD_KEY:
            begin
                // No MixColumns in the final round
                if (round == NR)
                    state_next = ST_DONE;
                else
                    state_next = ST_MIX;
            end
            ST_MIX:       state_next = ST_END_ROUND;
            ST_END_ROUND: state_next = ST_SB_START;
            ST_DONE:      state_next = ST_IDLE;
            default:      state_next = ST_IDLE;
        endcase
    end

    // Round counter and key address countdown
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state       <= ST_IDLE;
            round       <= '0;
            key_rd_addr <= NR;
        end
        else
        begin
            state <= state_next;
            case (state)
                ST_FIRST_ADD, ST_END_ROUND:
                begin
                    round       <= round + 1'b1;
                    key_rd_addr <= key_rd_addr - 1'b1;
                end
                ST_DONE:
                begin
                    round       <= '0;
                    key_rd_addr <= NR;
                end
                default:
                begin
                end
            endcase
        end
    end

    // Operand select with AddRoundKey folded in
    always_comb
    begin
        case (state)
            ST_FIRST_ADD: next_block = in_q ^ key_rd_data;
            ST_END_ROUND: next_block = mc_out;
            default:      next_block = sb_out ^ key_rd_data;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (state == ST_IDLE && data_in_valid)
            in_q <= data_in;
        if (state == ST_FIRST_ADD || state == ST_ADD_KEY || state == ST_END_ROUND)
            state_q <= next_block;
    end

    // Result register and strobe
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            data_out_valid <= 1'b0;
            data_out       <= '0;
        end
        else
        begin
            data_out_valid <= (state == ST_DONE);
            if (state == ST_DONE)
                data_out <= state_q;
        end
    end

    aes_inv_sub_bytes i_sub_bytes
    (
        .clk      (clk),
        .resetn   (resetn),
        .sb_start (sb_start),
        .sb_in    (state_q),
        .sb_done  (sb_done),
        .sb_out   (sb_out)
    );

    aes_inv_mix_columns i_mix_columns
    (
        .clk    (clk),
        .resetn (resetn),
        .mc_en  (mc_en),
        .mc_in  (state_q),
        .mc_out (mc_out)
    );

endmodule

// ==== hdl/aes_round_key_ram.sv ====
`timescale 1ns/1ps

`include "aes_dec_params.svh"

module aes_round_key_ram
(
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       key_wr_en,
    input  logic [`AES_DEC_KEY_AW-1:0] key_wr_addr,
    input  aes_dec_pkg::aes_state_t     key_wr_data,
    input  logic [`AES_DEC_KEY_AW-1:0] key_rd_addr,
    output aes_dec_pkg::aes_state_t     key_rd_data
);

    import aes_dec_pkg::*;

    // Entry r holds encryption round key r
    aes_state_t mem [`AES_DEC_NUM_KEYS];

    always_ff @(posedge clk)
    begin
        if (key_wr_en && (key_wr_addr < `AES_DEC_NUM_KEYS))
            mem[key_wr_addr] <= key_wr_data;
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            key_rd_data <= '0;
        else
            key_rd_data <= mem[key_rd_addr];
    end

endmodule

// ==== hdl/aes_inv_mix_columns.sv ====
`timescale 1ns/1ps

module aes_inv_mix_columns
(
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   mc_en,
    input  aes_dec_pkg::aes_state_t mc_in,
    output aes_dec_pkg::aes_state_t mc_out
);

    import aes_dec_pkg::*;

    aes_state_t mixed;

    function automatic aes_byte_t xtime(input aes_byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // Multiply by a constant below 16 from the xtime chain
    function automatic aes_byte_t gf_mul(input aes_byte_t b, input logic [3:0] k);
        aes_byte_t x2;
        aes_byte_t x4;
        aes_byte_t x8;
        x2 = xtime(b);
        x4 = xtime(x2);
        x8 = xtime(x4);
        return (k[0] ? b : 8'h00) ^ (k[1] ? x2 : 8'h00) ^
               (k[2] ? x4 : 8'h00) ^ (k[3] ? x8 : 8'h00);
    endfunction

    // Circulant matrix with rows 0e 0b 0d 09
    function automatic aes_word_t inv_mix_word(input aes_word_t w);
        aes_byte_t a0;
        aes_byte_t a1;
        aes_byte_t a2;
        aes_byte_t a3;
        a0 = w[31:24];
        a1 = w[23:16];
        a2 = w[15:8];
        a3 = w[7:0];
        return {gf_mul(a0, 4'he) ^ gf_mul(a1, 4'hb) ^ gf_mul(a2, 4'hd) ^ gf_mul(a3, 4'h9),
                gf_mul(a0, 4'h9) ^ gf_mul(a1, 4'he) ^ gf_mul(a2, 4'hb) ^ gf_mul(a3, 4'hd),
                gf_mul(a0, 4'hd) ^ gf_mul(a1, 4'h9) ^ gf_mul(a2, 4'he) ^ gf_mul(a3, 4'hb),
                gf_mul(a0, 4'hb) ^ gf_mul(a1, 4'hd) ^ gf_mul(a2, 4'h9) ^ gf_mul(a3, 4'he)};
    endfunction

    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            mixed[127 - 32 * c -: 32] = inv_mix_word(mc_in[127 - 32 * c -: 32]);
        end
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            mc_out <= '0;
        else if (mc_en)
            mc_out <= mixed;
    end

endmodule

// ==== hdl/aes_inv_sub_bytes.sv ====
`timescale 1ns/1ps

module aes_inv_sub_bytes
(
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   sb_start,
    input  aes_dec_pkg::aes_state_t sb_in,
    output logic                   sb_done,
    output aes_dec_pkg::aes_state_t sb_out
);

    import aes_dec_pkg::*;

    aes_state_t shift_q;
    aes_state_t collect_q;
    aes_byte_t  sbox_data;
    logic [3:0] feed_cnt;
    logic       feed_active;
    logic [3:0] coll_cnt;
    logic       coll_active;

    // Row r rotates right by r columns
    function automatic aes_state_t inv_shift_rows(input aes_state_t s);
        aes_state_t r;
        for (int c = 0; c < 4; c++)
        begin
            for (int row = 0; row < 4; row++)
            begin
                r[127 - 8 * (row + 4 * c) -: 8] =
                    s[127 - 8 * (row + 4 * ((c - row) & 3)) -: 8];
            end
        end
        return r;
    endfunction

    aes_inv_sbox i_sbox
    (
        .clk    (clk),
        .resetn (resetn),
        .addr   (shift_q[127:120]),
        .data   (sbox_data)
    );

    // Feed side starts with byte 0
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            feed_active <= 1'b0;
            feed_cnt    <= '0;
        end
        else if (sb_start)
        begin
            feed_active <= 1'b1;
            feed_cnt    <= '0;
        end
        else if (feed_active)
        begin
            feed_cnt <= feed_cnt + 4'd1;
            if (feed_cnt == 4'd15)
                feed_active <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (sb_start)
            shift_q <= inv_shift_rows(sb_in);
        else if (feed_active)
            shift_q <= {shift_q[119:0], 8'h00};
    end

    // Collect side trails the feed by the ROM register
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            coll_active <= 1'b0;
            coll_cnt    <= '0;
            sb_done     <= 1'b0;
        end
        else
        begin
            coll_active <= feed_active;
            coll_cnt    <= feed_cnt;
            sb_done     <= coll_active && (coll_cnt == 4'd15);
        end
    end

    always_ff @(posedge clk)
    begin
        if (coll_active)
            collect_q <= {collect_q[119:0], sbox_data};
    end

    assign sb_out = collect_q;

endmodule

// ==== hdl/aes_inv_sbox.sv ====
`timescale 1ns/1ps

module aes_inv_sbox
(
    input  logic                  clk,
    input  logic                  resetn,
    input  aes_dec_pkg::aes_byte_t addr,
    output aes_dec_pkg::aes_byte_t data
);

    import aes_dec_pkg::*;

    // Inverse S-box with entry 0x00 in the top byte
    localparam logic [2047:0] INV_SBOX =
    {
        128'h52096ad53036a538bf40a39e81f3d7fb,
        128'h7ce339829b2fff87348e4344c4dee9cb,
        128'h547b9432a6c2233dee4c950b42fac34e,
        128'h082ea16628d924b2765ba2496d8bd125,
        128'h72f8f66486689816d4a45ccc5d65b692,
        128'h6c704850fdedb9da5e154657a78d9d84,
        128'h90d8ab008cbcd30af7e45805b8b34506,
        128'hd02c1e8fca3f0f02c1afbd0301138a6b,
        128'h3a9111414f67dcea97f2cfcef0b4e673,
        128'h96ac7422e7ad3585e2f937e81c75df6e,
        128'h47f11a711d29c5896fb7620eaa18be1b,
        128'hfc563e4bc6d279209adbc0fe78cd5af4,
        128'h1fdda8338807c731b11210592780ec5f,
        128'h60517fa919b54a0d2de57a9f93c99cef,
        128'ha0e03b4dae2af5b0c8ebbb3c83539961,
        128'h172b047eba77d626e169146355210c7d
    };

    aes_byte_t rom_word;

    assign rom_word = INV_SBOX[2047 - 8 * addr -: 8];

    // One cycle read latency
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            data <= '0;
        end
        else
        begin
            data <= rom_word;
        end
    end

endmodule

// ==== hdl/aes_dec_pkg.sv ====
package aes_dec_pkg;

    // Single state byte
    typedef logic [7:0] aes_byte_t;

    // One state column with row 0 in the top byte
    typedef logic [31:0] aes_word_t;

    // Byte 0 in bits 127:120 in column-major byte order
    typedef logic [127:0] aes_state_t;

    // Controller states
    typedef enum logic [3:0]
    {
        ST_IDLE      = 4'd0,
        ST_FIRST_ADD = 4'd1,
        ST_SB_START  = 4'd2,
        ST_SB_WAIT   = 4'd3,
        ST_ADD_KEY   = 4'd4,
        ST_MIX       = 4'd5,
        ST_END_ROUND = 4'd6,
        ST_DONE      = 4'd7
    } dec_state_e;

endpackage

// ==== hdl/aes_dec_params.svh ====
`ifndef AES_DEC_PARAMS_SVH
`define AES_DEC_PARAMS_SVH

// Inverse rounds for a 256-bit key
`define AES_DEC_ROUNDS    14

// Round keys 0 to 14
`define AES_DEC_NUM_KEYS  15

`define AES_DEC_KEY_AW    4

`endif
